//--- project.f
+incdir+common
common/alu_pkg.sv
common/flags_pkg.sv
alu/alu_flags.sv
alu/alu_daa.sv
alu/alu32.sv
logic/eflags_reg.sv
logic/exec_stage.sv
verif/tb_clock.sv
verif/exec_asserts.sv
verif/exec_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module exec_tb \
	-Mdir obj_dir -o exec_sim &&
	./obj_dir/exec_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log && echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }

//--- verif/exec_tb.sv
//----------------------------
// Execute stage testbench
// Directed and xorshift requests
// Failure monitor, watchdog
//----------------------------
`include "exec_defs.svh"

module exec_tb import alu_pkg::*, flags_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int period_ns    = 100;
	localparam int num_directed = 40;
	localparam int num_random   = 400;

	logic        clk;
	logic        rst_n;
	exec_req_t   req;
	exec_rsp_t   rsp;
	eflags_u     eflags;
	logic [31:0] rng_state;
	logic        fail_seen;

	tb_clock #(.period_ns(period_ns), .reset_cycles(8)) clock_i (.clk(clk), .rst_n(rst_n));

	exec_stage dut_i (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp), .eflags(eflags));

	// Any assertion of the bound checker fired
	assign fail_seen = dut_i.asserts_i.fail_valid | dut_i.asserts_i.fail_result |
		dut_i.asserts_i.fail_flags;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Sign boundaries at byte, word and dword
	function automatic logic [31:0] corner_value(input logic [1:0] sel);
		case (sel)
			2'd0:    return 32'h0000_0000;
			2'd1:    return 32'hffff_ffff;
			2'd2:    return 32'h7fff_7f7f;
			default: return 32'h8000_8080;
		endcase
	endfunction

	task automatic send(input alu_op_e op, input data_size_e size, input logic [31:0] a,
		input logic [31:0] b);
		@(posedge clk);
		#10;
		req.valid = 1'b1;
		req.op    = op;
		req.size  = size;
		req.a     = a;
		req.b     = b;
	endtask

	// No request, other fields scrambled
	task automatic idle();
		@(posedge clk);
		#10;
		req.valid = 1'b0;
		req.op    = ALU_STD;
		req.a     = rng_state;
		req.b     = ~rng_state;
	endtask

	// BCD add, then DAA on the sum in the next cycle
	task automatic bcd_add(input logic [7:0] x, input logic [7:0] y);
		logic [7:0] sum;
		sum = x + y;
		send(ALU_ADD, SIZE_BYTE, {24'h0, x}, {24'h0, y});
		send(ALU_DAA, SIZE_BYTE, {24'h0, sum}, 32'h0);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
	endtask

	//----------------------------
	// Monitor and watchdog
	//----------------------------
	initial begin : failure_monitor
		wait (fail_seen);
		if (dut_i.asserts_i.fail_valid)
			report_mismatch("rsp.valid", {31'h0, dut_i.asserts_i.exp_valid}, {31'h0, rsp.valid});
		if (dut_i.asserts_i.fail_result)
			report_mismatch("rsp.result", dut_i.asserts_i.exp_result, rsp.result);
		if (dut_i.asserts_i.fail_flags)
			report_mismatch("eflags", dut_i.asserts_i.exp_eflags, eflags.raw);
		$display("STATUS: FAIL");
		$fatal(1, "assertion failed");
	end

	initial begin : watchdog
		#((num_directed + num_random + 20) * period_ns);
		$display("Timeout: test did not finish within %0d cycles",
			num_directed + num_random + 20);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	//----------------------------
	// Stimulus
	//----------------------------
	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		req = '0;
		rng_state = 32'd45;
		@(posedge rst_n);
		idle();
		// Carry out and signed overflow per size
		send(ALU_ADD, SIZE_BYTE, 32'h0000_00ff, 32'h0000_0001);
		send(ALU_ADD, SIZE_BYTE, 32'h0000_007f, 32'h0000_0001);
		send(ALU_ADD, SIZE_WORD, 32'h0000_ffff, 32'h0000_0001);
		send(ALU_ADD, SIZE_WORD, 32'h0000_7fff, 32'h0000_0001);
		send(ALU_ADD, SIZE_DWORD, 32'hffff_ffff, 32'h0000_0001);
		send(ALU_ADD, SIZE_DWORD, 32'h7fff_ffff, 32'h0000_0001);
		send(ALU_ADD, SIZE_DWORD, 32'h8000_0000, 32'h8000_0000);
		// Borrow and overflow on compare
		send(ALU_CMP, SIZE_BYTE, 32'h0000_0000, 32'h0000_0001);
		send(ALU_CMP, SIZE_BYTE, 32'h0000_0080, 32'h0000_0001);
		send(ALU_CMP, SIZE_WORD, 32'h0000_8000, 32'h0000_0001);
		send(ALU_CMP, SIZE_WORD, 32'h0000_0000, 32'h0000_0001);
		send(ALU_CMP, SIZE_DWORD, 32'h8000_0000, 32'h0000_0001);
		send(ALU_CMP, SIZE_DWORD, 32'h0000_0005, 32'h0000_0005);
		// Set CF and OF, then NOT, idle, logic ops
		send(ALU_ADD, SIZE_DWORD, 32'h8000_0000, 32'h8000_0000);
		send(ALU_NOT, SIZE_DWORD, 32'h1234_5678, 32'h0);
		idle();
		send(ALU_OR, SIZE_BYTE, 32'h0000_000f, 32'h0000_00f0);
		send(ALU_ADD, SIZE_BYTE, 32'h0000_0088, 32'h0000_0088);
		send(ALU_AND, SIZE_WORD, 32'h0000_00ff, 32'h0000_ff00);
		// Direction flag
		send(ALU_STD, SIZE_DWORD, 32'hdead_beef, 32'h1);
		send(ALU_ADD, SIZE_BYTE, 32'h0000_0001, 32'h0000_0002);
		send(ALU_CLD, SIZE_DWORD, 32'h0, 32'h0);
		send(ALU_STD, SIZE_DWORD, 32'h0, 32'h0);
		send(ALU_STD, SIZE_DWORD, 32'h0, 32'h0);
		send(ALU_CLD, SIZE_DWORD, 32'h0, 32'h0);
		// No adjust, low, low via AF, high, both
		bcd_add(8'h12, 8'h34);
		bcd_add(8'h15, 8'h27);
		bcd_add(8'h19, 8'h28);
		bcd_add(8'h50, 8'h60);
		bcd_add(8'h99, 8'h99);
		idle();
		idle();
		repeat (num_random) begin
			rng_state = xorshift32(rng_state);
			r = rng_state;
			rng_state = xorshift32(rng_state);
			a = rng_state;
			rng_state = xorshift32(rng_state);
			b = rng_state;
			if (r[11:9] == 3'd0) begin
				a = corner_value(r[13:12]);
			end
			// Equal operands for ZF
			if (r[15:14] == 2'd0) begin
				b = a;
			end
			if (r[3:0] == 4'd0) begin
				idle();
			end else begin
				send(alu_op_e'(r[6:4]), (r[8:7] == 2'd3) ? SIZE_DWORD : data_size_e'(r[8:7]),
					a, b);
			end
		end
		idle();
		repeat (2) @(posedge clk);
		@(negedge clk);
		#1;
		if (fail_seen) begin
			$display("STATUS: FAIL");
			$fatal(1, "assertion failed");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

//--- verif/exec_asserts.sv
//----------------------------
// Execute stage checker
// Reference model of result and
// EFLAGS, concurrent assertions
//----------------------------
`include "exec_defs.svh"

module exec_asserts import alu_pkg::*, flags_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input exec_req_t req,
	input exec_rsp_t rsp,
	input eflags_u   eflags
);
	timeunit 1ns;
	timeprecision 100ps;

	logic                    exp_valid;
	logic [`EXEC_DATA_W-1:0] exp_result;
	logic [`EXEC_DATA_W-1:0] exp_eflags;
	logic [`EXEC_DATA_W-1:0] nxt_result;
	logic [`EXEC_DATA_W-1:0] nxt_eflags;
	// Sticky markers, watched by the testbench
	logic                    fail_valid = 1'b0;
	logic                    fail_result = 1'b0;
	logic                    fail_flags = 1'b0;

	// Sign bit at operand size
	function automatic logic msb_of(input logic [31:0] v, input data_size_e s);
		case (s)
			SIZE_BYTE: return v[7];
			SIZE_WORD: return v[15];
			default:   return v[31];
		endcase
	endfunction

	// Operand cut to its size, one spare bit for carry
	function automatic logic [32:0] lane(input logic [31:0] v, input data_size_e s);
		case (s)
			SIZE_BYTE: return {25'h0, v[7:0]};
			SIZE_WORD: return {17'h0, v[15:0]};
			default:   return {1'b0, v};
		endcase
	endfunction

	//----------------------------
	// Next model state
	//----------------------------
	always_comb begin : model_next
		logic [7:0]   al;
		logic         lo_adj;
		logic         hi_adj;
		logic         upd;
		data_size_e   sz;
		arith_flags_t f;
		f = '0;
		upd = 1'b1;
		sz = (req.op == ALU_DAA) ? SIZE_BYTE : req.size;
		al = req.a[7:0];
		// x86 DAA rule on the forwarded CF and AF
		lo_adj = (al[3:0] > 4'd9) || exp_eflags[`EXEC_AF_BIT];
		hi_adj = (al > 8'h99) || exp_eflags[`EXEC_CF_BIT];
		nxt_eflags = exp_eflags;
		case (req.op)
			ALU_ADD: begin
				nxt_result = req.a + req.b;
				f.cf = (lane(req.a, sz) + lane(req.b, sz)) > lane('1, sz);
				f.af = ({1'b0, req.a[3:0]} + {1'b0, req.b[3:0]}) > 5'd15;
				// Same operand signs, different result sign
				f.of = (msb_of(req.a, sz) == msb_of(req.b, sz)) &&
					(msb_of(nxt_result, sz) != msb_of(req.a, sz));
			end
			ALU_CMP: begin
				nxt_result = req.a - req.b;
				f.cf = lane(req.a, sz) < lane(req.b, sz);
				f.af = req.a[3:0] < req.b[3:0];
				f.of = (msb_of(req.a, sz) != msb_of(req.b, sz)) &&
					(msb_of(nxt_result, sz) != msb_of(req.a, sz));
			end
			ALU_OR:  nxt_result = req.a | req.b;
			ALU_AND: nxt_result = req.a & req.b;
			ALU_NOT: begin
				nxt_result = ~req.a;
				upd = 1'b0;
			end
			ALU_DAA: begin
				nxt_result = {24'h0, al + (lo_adj ? 8'h06 : 8'h00) + (hi_adj ? 8'h60 : 8'h00)};
				f.cf = hi_adj;
				f.af = lo_adj;
			end
			// CLD and STD touch DF only
			default: begin
				nxt_result = '0;
				upd = 1'b0;
				nxt_eflags[`EXEC_DF_BIT] = (req.op == ALU_STD);
			end
		endcase
		f.sf = msb_of(nxt_result, sz);
		f.zf = (lane(nxt_result, sz) == 33'd0);
		f.pf = ~^nxt_result[7:0];
		if (upd) begin
			nxt_eflags[`EXEC_CF_BIT] = f.cf;
			nxt_eflags[`EXEC_PF_BIT] = f.pf;
			nxt_eflags[`EXEC_AF_BIT] = f.af;
			nxt_eflags[`EXEC_ZF_BIT] = f.zf;
			nxt_eflags[`EXEC_SF_BIT] = f.sf;
			nxt_eflags[`EXEC_OF_BIT] = f.of;
		end
	end

	// Model registers, same edge as the DUT
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_valid  <= 1'b0;
			exp_result <= '0;
			exp_eflags <= `EXEC_EFLAGS_RESET;
		end else begin
			exp_valid <= req.valid;
			if (req.valid) begin
				exp_result <= nxt_result;
				exp_eflags <= nxt_eflags;
			end
		end
	end

	//----------------------------
	// Checks, mid-cycle
	//----------------------------
	a_rsp_valid: assert property (@(negedge clk) disable iff (!rst_n) rsp.valid == exp_valid)
		else begin
			fail_valid = 1'b1;
			$error("rsp.valid differs from model");
		end

	a_rsp_result: assert property (@(negedge clk) disable iff (!rst_n) rsp.result == exp_result)
		else begin
			fail_result = 1'b1;
			$error("rsp.result differs from model");
		end

	a_eflags: assert property (@(negedge clk) disable iff (!rst_n) eflags.raw == exp_eflags)
		else begin
			fail_flags = 1'b1;
			$error("eflags differs from model");
		end

endmodule

bind exec_stage exec_asserts asserts_i (
	.clk    (clk),
	.rst_n  (rst_n),
	.req    (req),
	.rsp    (rsp),
	.eflags (eflags)
);

//--- verif/tb_clock.sv
//----------------------------
// Testbench clock and reset
//----------------------------
module tb_clock #(
	parameter int period_ns    = 100,
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// Free-running clock
	initial begin
		clk = 1'b0;
		forever begin
			#(period_ns / 2);
			clk = ~clk;
		end
	end

	// Reset released off the clock edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#10;
		rst_n = 1'b1;
	end

endmodule

//--- logic/exec_stage.sv
//----------------------------
// Execute stage top
// ALU, result reg, EFLAGS
//----------------------------
`include "exec_defs.svh"

module exec_stage import alu_pkg::*, flags_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  exec_req_t req,
	output exec_rsp_t rsp,
	output eflags_u   eflags
);

	logic [`EXEC_DATA_W-1:0] alu_result;
	arith_flags_t            alu_fl;

	// CF/AF forwarded from the live register for DAA
	alu32 alu_i (
		.a      (req.a),
		.b      (req.b),
		.op     (req.op),
		.size   (req.size),
		.cf_in  (eflags.bits.cf),
		.af_in  (eflags.bits.af),
		.result (alu_result),
		.flags  (alu_fl)
	);

	// Flags land on the same edge as the result
	eflags_reg flags_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.upd    (req.valid),
		.op     (req.op),
		.arith  (alu_fl),
		.eflags (eflags)
	);

	//----------------------------
	// Result register
	//----------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp <= '0;
		end else begin
			// One-cycle strobe, not held
			rsp.valid <= req.valid;
			if (req.valid) begin
				rsp.result <= alu_result;
			end
		end
	end

endmodule

//--- logic/eflags_reg.sv
//----------------------------
// Architectural EFLAGS
// Per-op update rules
//----------------------------
`include "exec_defs.svh"

module eflags_reg import alu_pkg::*, flags_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         upd,
	input  alu_op_e      op,
	input  arith_flags_t arith,
	output eflags_u      eflags
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			eflags.raw <= `EXEC_EFLAGS_RESET;
		end else if (upd) begin
			case (op)
				// Logic ops arrive with OF/CF/AF already low
				ALU_ADD, ALU_CMP, ALU_DAA, ALU_OR, ALU_AND: begin
					eflags.bits.of <= arith.of;
					eflags.bits.sf <= arith.sf;
					eflags.bits.zf <= arith.zf;
					eflags.bits.af <= arith.af;
					eflags.bits.pf <= arith.pf;
					eflags.bits.cf <= arith.cf;
				end
				// Direction flag only
				ALU_CLD: eflags.bits.df <= 1'b0;
				ALU_STD: eflags.bits.df <= 1'b1;
				// NOT leaves flags alone
				default: eflags <= eflags;
			endcase
		end
	end

endmodule

//--- alu/alu32.sv
//----------------------------
// 32-bit ALU
// ADD, OR, NOT, DAA, AND, CLD,
// CMP, STD with result and
// flag selection
//----------------------------
`include "exec_defs.svh"

module alu32 import alu_pkg::*; (
	input  logic [`EXEC_DATA_W-1:0] a,
	input  logic [`EXEC_DATA_W-1:0] b,
	input  alu_op_e                 op,
	input  data_size_e              size,
	input  logic                    cf_in,
	input  logic                    af_in,
	output logic [`EXEC_DATA_W-1:0] result,
	output arith_flags_t            flags
);

	//----------------------------
	// Datapath results
	//----------------------------
	logic [`EXEC_DATA_W-1:0] add_res;
	logic [`EXEC_DATA_W-1:0] sub_res;
	logic [`EXEC_DATA_W-1:0] or_res;
	logic [`EXEC_DATA_W-1:0] and_res;
	logic [`EXEC_DATA_W-1:0] not_res;
	logic [`EXEC_DATA_W-1:0] daa_res;

	// Per-bit carry and borrow out
	logic [`EXEC_DATA_W-1:0] add_carry;
	logic [`EXEC_DATA_W-1:0] sub_borrow;
	logic [`EXEC_DATA_W-1:0] carry_sel;

	// Flag sources
	logic                    is_arith;
	arith_flags_t            gen_flags;
	arith_flags_t            daa_flags;

	// Adder and subtractor
	assign add_res = a + b;
	assign sub_res = a - b;

	// Carry into each bit is a^b^sum
	// Carry out is then the majority term
	assign add_carry = (a & b) | ((a ^ b ^ add_res) & (a ^ b));

	// Borrow out when b wins, or equal bits with borrow in
	assign sub_borrow = (~a & b) | (~(a ^ b) & (a ^ b ^ sub_res));

	// Logic ops
	assign or_res  = a | b;
	assign and_res = a & b;
	assign not_res = ~a;

	// Decimal adjust works on AL only
	alu_daa daa_i (
		.al     (a[7:0]),
		.cf_in  (cf_in),
		.af_in  (af_in),
		.result (daa_res),
		.flags  (daa_flags)
	);

	//----------------------------
	// Flag generation
	//----------------------------
	// CMP is the only subtracting op
	assign carry_sel = (op == ALU_CMP) ? sub_borrow : add_carry;
	assign is_arith  = (op == ALU_ADD) || (op == ALU_CMP);

	alu_flags flags_i (
		.result (result),
		.a      (a),
		.b      (b),
		.carry  (carry_sel),
		.size   (size),
		.arith  (is_arith),
		.flags  (gen_flags)
	);

	//----------------------------
	// Output selection
	//----------------------------
	always_comb begin
		// CLD and STD have no data result
		result = '0;
		case (op)
			ALU_ADD: result = add_res;
			ALU_OR:  result = or_res;
			ALU_NOT: result = not_res;
			ALU_DAA: result = daa_res;
			ALU_AND: result = and_res;
			ALU_CMP: result = sub_res;
			ALU_CLD: result = '0;
			ALU_STD: result = '0;
			default: result = '0;
		endcase
	end

	// DAA brings its own flag rules
	// NOT/CLD/STD flags are ignored downstream
	assign flags = (op == ALU_DAA) ? daa_flags : gen_flags;

endmodule

//--- alu/alu_daa.sv
//----------------------------
// Decimal adjust after add
// Adjusted AL and its flags
//----------------------------
`include "exec_defs.svh"

module alu_daa import alu_pkg::*; (
	input  logic [7:0]              al,
	input  logic                    cf_in,
	input  logic                    af_in,
	output logic [`EXEC_DATA_W-1:0] result,
	output arith_flags_t            flags
);

	logic       low_adj;
	logic       high_adj;
	logic [7:0] al_low;
	logic [7:0] al_adj;

	// Low digit out of BCD range or nibble carry seen
	assign low_adj = (al[3:0] > 4'd9) || af_in;

	// High test uses the original AL, not the low-adjusted one
	assign high_adj = (al > 8'h99) || cf_in;

	// Two-step correction, byte wraps
	assign al_low = al + (low_adj ? 8'h06 : 8'h00);
	assign al_adj = al_low + (high_adj ? 8'h60 : 8'h00);

	// Only AL is written
	assign result = {{(`EXEC_DATA_W-8){1'b0}}, al_adj};

	//----------------------------
	// Flags
	//----------------------------
	// OF is undefined on x86, forced low
	assign flags.of = 1'b0;
	assign flags.sf = al_adj[7];
	assign flags.zf = (al_adj == 8'h00);
	assign flags.af = low_adj;
	assign flags.pf = ~^al_adj;
	assign flags.cf = high_adj;

endmodule

//--- alu/alu_flags.sv
//----------------------------
// Size-aware status flags
// OF SF ZF AF PF CF
//----------------------------
`include "exec_defs.svh"

module alu_flags import alu_pkg::*; (
	input  logic [`EXEC_DATA_W-1:0] result,
	input  logic [`EXEC_DATA_W-1:0] a,
	input  logic [`EXEC_DATA_W-1:0] b,
	input  logic [`EXEC_DATA_W-1:0] carry,
	input  data_size_e              size,
	input  logic                    arith,
	output arith_flags_t            flags
);

	// Top bit index and valid lanes for this size
	logic [4:0]              msb;
	logic [`EXEC_DATA_W-1:0] size_mask;
	logic                    carry_in_msb;
	logic                    carry_out_msb;

	always_comb begin
		case (size)
			SIZE_BYTE: begin
				msb       = 5'd7;
				size_mask = `EXEC_DATA_W'h0000_00ff;
			end
			SIZE_WORD: begin
				msb       = 5'd15;
				size_mask = `EXEC_DATA_W'h0000_ffff;
			end
			// Dword, also the unused code
			default: begin
				msb       = 5'd31;
				size_mask = '1;
			end
		endcase
	end

	// Carry into the top bit recovered from the sum
	assign carry_in_msb  = a[msb] ^ b[msb] ^ result[msb];
	assign carry_out_msb = carry[msb];

	// Overflow when carry in and out of the sign bit differ
	// Holds for borrow as well
	assign flags.of = arith & (carry_in_msb ^ carry_out_msb);
	assign flags.sf = result[msb];
	assign flags.zf = ((result & size_mask) == '0);

	// Nibble carry for BCD
	assign flags.af = arith & carry[3];

	// Even parity of the low byte only
	assign flags.pf = ~^result[7:0];
	assign flags.cf = arith & carry_out_msb;

endmodule

//--- common/flags_pkg.sv
//----------------------------
// EFLAGS types
// Named bit layout and the
// word/field union over it
//----------------------------
`include "exec_defs.svh"

package flags_pkg;

	// Architectural layout, LSB last
	typedef struct packed {
		// Everything above OF is not modelled here
		logic [`EXEC_DATA_W-`EXEC_OF_BIT-2:0] rsvd_hi;
		logic       of;
		logic       df;
		// TF and IF not implemented
		logic [1:0] rsvd_9_8;
		logic       sf;
		logic       zf;
		logic       rsvd_5;
		logic       af;
		logic       rsvd_3;
		logic       pf;
		// Always one on x86
		logic       rsvd_1;
		logic       cf;
	} eflags_bits_t;

	// Same word seen raw or by field
	typedef union packed {
		logic [`EXEC_DATA_W-1:0] raw;
		eflags_bits_t            bits;
	} eflags_u;

endpackage

//--- common/alu_pkg.sv
//----------------------------
// ALU types
// Operation and size encodings
// Request, response, arith flags
//----------------------------
`include "exec_defs.svh"

package alu_pkg;

	// Opcode encoding in ALU result mux order
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_OR  = 3'd1,
		ALU_NOT = 3'd2,
		ALU_DAA = 3'd3,
		ALU_AND = 3'd4,
		ALU_CLD = 3'd5,
		ALU_CMP = 3'd6,
		ALU_STD = 3'd7
	} alu_op_e;

	// Operand size with code 3 never issued
	typedef enum logic [1:0] {
		SIZE_BYTE  = 2'd0,
		SIZE_WORD  = 2'd1,
		SIZE_DWORD = 2'd2
	} data_size_e;

	// One request per clock with no back-pressure
	typedef struct packed {
		logic                    valid;
		alu_op_e                 op;
		data_size_e              size;
		logic [`EXEC_DATA_W-1:0] a;
		logic [`EXEC_DATA_W-1:0] b;
	} exec_req_t;

	// Registered result
	typedef struct packed {
		logic                    valid;
		logic [`EXEC_DATA_W-1:0] result;
	} exec_rsp_t;

	// Status flags produced by the ALU
	typedef struct packed {
		logic of;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} arith_flags_t;

endpackage

//--- common/exec_defs.svh
//----------------------------
// Execute stage constants
// Data width, EFLAGS bit positions
// and the flag value after reset
//----------------------------
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Operand and result width
`define EXEC_DATA_W 32

// EFLAGS bit positions
`define EXEC_CF_BIT 0
`define EXEC_PF_BIT 2
`define EXEC_AF_BIT 4
`define EXEC_ZF_BIT 6
`define EXEC_SF_BIT 7
`define EXEC_DF_BIT 10
`define EXEC_OF_BIT 11

// Only reserved bit 1 reads as one
`define EXEC_EFLAGS_RESET 32'h0000_0002

`endif
